// ==== flist.f ====
+incdir+rtl
rtl/tank_pkg.sv
rtl/step_tick.sv
rtl/enemy_tank.sv
rtl/shot_fifo.sv
rtl/enemy_bullet.sv
rtl/enemy_top.sv
verification/enemy_checker.sv
verification/tb_enemy_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the enemy_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_enemy_top -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "tests failed" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
echo "simulation clean"

// ==== verification/tb_enemy_top.sv ====
`timescale 1ns/1ps
`include "tank_cfg.svh"

module tb_enemy_top;

	localparam int NUM_TESTS = 5;
	localparam int STEP_CYC  = `TANK_STEP_DIV;

	logic            clk;
	logic            rst_n;
	logic            enable;
	logic            respawn;
	logic            frozen;
	logic [1:0]      tank_num;
	tank_pkg::pos_t  player_pos;
	tank_pkg::pos_t  player_bul_pos;
	logic            player_bul_valid;
	tank_pkg::pos_t  enemy_pos;
	tank_pkg::dir_e  enemy_dir;
	logic            enemy_alive;
	logic [4:0]      score;
	tank_pkg::pos_t  bul_pos;
	logic            bul_active;
	logic            player_hit;
	logic            test_end;
	logic [2:0]      test_num;
	logic            tb_fail;
	int              n_fail;
	int              n_err;
	logic [31:0]     lfsr;
	logic [4:0]      score0;
	int              hits;

	enemy_top i_enemy_top (.*);

	enemy_checker i_checker (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;                       // 8 ns period
	end

	// watchdog sized for every test at 400 steps
	initial
	begin
		#(NUM_TESTS * 400 * STEP_CYC * 8);
		$display("watchdog expired, run stopped");
		$display("tests failed");
		$finish;
	end

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic int take_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v    = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	task automatic tick(int n);
		repeat (n) @(posedge clk);
		#1;                                          // drive just after the edge
	endtask

	task automatic flag_failure(string msg);
		$display("%s", msg);
		tb_fail = 1'b1;
		tick(1);
		tb_fail = 1'b0;
	endtask

	task automatic wait_alive(logic lvl, int max_cyc);
		int n;
		n = 0;
		while (enemy_alive !== lvl && n < max_cyc)
		begin
			tick(1);
			n++;
		end
		if (enemy_alive !== lvl)
			flag_failure($sformatf("timeout waiting for enemy_alive to become %0b", lvl));
	endtask

	task automatic spawn_tank(logic [1:0] n);
		tank_num = n;
		respawn  = 1'b1;
		tick(1);
		respawn  = 1'b0;
		wait_alive(1'b1, 4 * STEP_CYC);
	endtask

	task automatic kill_by_bullet();
		player_bul_pos   = enemy_pos;
		player_bul_valid = 1'b1;
		wait_alive(1'b0, 4);
		player_bul_valid = 1'b0;
	endtask

	// the tank chases a still player until it dies
	task automatic chase_player(tank_pkg::pos_t p, logic [1:0] n);
		frozen = 1'b1;
		spawn_tank(n);
		player_pos = p;
		tick(3 * STEP_CYC);                          // tank holds while frozen
		enable = 1'b0;
		tick(2 * STEP_CYC);                          // tank holds while disabled
		enable = 1'b1;
		frozen = 1'b0;
		for (int i = 0; i < 400 * STEP_CYC && enemy_alive; i++)
		begin
			tick(1);
			hits += int'(player_hit);
		end
		if (enemy_alive)
			flag_failure("tank never reached the player");
	endtask

	// queue drained once the bullet stays idle for a few cycles
	task automatic drain_bullets();
		int idle;
		int n;
		idle = 0;
		n    = 0;
		while (idle < 8 && n < 400 * STEP_CYC)
		begin
			tick(1);
			hits += int'(player_hit);
			idle = bul_active ? 0 : idle + 1;
			n++;
		end
		if (idle < 8)
			flag_failure("bullets never drained");
	endtask

	task automatic finish_test();
		test_end = 1'b1;
		tick(1);
		test_end = 1'b0;
		test_num = test_num + 3'd1;
	endtask

	initial
	begin
		rst_n            = 1'b0;
		enable           = 1'b1;
		respawn          = 1'b0;
		frozen           = 1'b1;
		tank_num         = 2'd0;
		player_pos       = '{x: 5'd8, y: 5'd6};
		player_bul_pos   = '0;
		player_bul_valid = 1'b0;
		test_end         = 1'b0;
		test_num         = 3'd0;
		tb_fail          = 1'b0;
		lfsr             = 32'hc9c2_582d;
		hits             = 0;
		tick(8);
		rst_n = 1'b1;
		tick(2);

		// spawn at all four corners
		for (int n = 0; n < 4; n++)
		begin
			spawn_tank(2'(n));
			kill_by_bullet();
		end
		finish_test();

		// chase random player cells
		for (int r = 0; r < 6; r++)
		begin
			tank_pkg::pos_t p;
			p.x = 5'(take_bits(5) % (`TANK_X_MAX + 1));
			p.y = 5'(take_bits(5) % (`TANK_Y_MAX + 1));
			chase_player(p, 2'(take_bits(2)));
		end
		drain_bullets();
		finish_test();

		// kills and score clear
		player_pos = '{x: 5'd8, y: 5'd10};
		score0     = score;
		for (int k = 0; k < 3; k++)
		begin
			spawn_tank(2'(k));
			kill_by_bullet();
		end
		if (score != 5'(score0 + 5'd3))
		begin
			$display("error hit_score: score expected %h actual %h", 5'(score0 + 5'd3), score);
			flag_failure("score count wrong");
		end
		enable = 1'b0;
		tick(2);
		if (score != 5'd0)
		begin
			$display("error hit_score: cleared score expected %h actual %h", 5'd0, score);
			flag_failure("score not cleared");
		end
		enable = 1'b1;
		finish_test();

		// chase along a row that overflows the queue
		chase_player('{x: 5'd2, y: 5'd0}, 2'd1);
		drain_bullets();
		finish_test();

		// chase along a column until a bullet meets the player
		hits = 0;
		chase_player('{x: 5'd0, y: 5'd3}, 2'd2);
		drain_bullets();
		if (hits == 0)
			flag_failure("player_hit never pulsed");
		finish_test();

		tick(2);
		$display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, n_fail, n_err);
		if (n_fail == 0 && n_err == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== verification/enemy_checker.sv ====
`timescale 1ns/1ps
`include "tank_cfg.svh"

module enemy_checker (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              enable,
	input  logic              frozen,
	input  logic [1:0]        tank_num,
	input  tank_pkg::pos_t    player_pos,
	input  tank_pkg::pos_t    player_bul_pos,
	input  logic              player_bul_valid,
	input  tank_pkg::pos_t    enemy_pos,
	input  tank_pkg::dir_e    enemy_dir,
	input  logic              enemy_alive,
	input  logic [4:0]        score,
	input  tank_pkg::pos_t    bul_pos,
	input  logic              bul_active,
	input  logic              player_hit,
	input  logic              test_end,               // one cycle at the end of a test
	input  logic [2:0]        test_num,
	input  logic              tb_fail,                // failure seen by the stimulus side
	output int                n_fail,
	output int                n_err
);

	tank_pkg::pos_t   prev_pos, prev_bul, prev_player, prev_bulp;
	logic             prev_alive, prev_active, prev_bulv, prev_frozen, prev_enable;
	logic [4:0]       prev_score;
	logic [1:0]       prev_tnum;
	tank_pkg::dir_e   fly_dir;                        // heading of the bullet in flight
	tank_pkg::shot_t  shot_q[$];                      // model of the shot queue
	tank_pkg::shot_t  pend_shot;
	tank_pkg::shot_t  nxt;
	tank_pkg::shot_t  front;
	tank_pkg::pos_t   exp_pos;
	logic             pend;                           // fired, enters the queue next clock
	logic             fire;
	logic             off;
	int               size_before;
	int               errs;                           // errors in the running test

	function automatic string test_name(logic [2:0] n);
		case (n)
			3'd0:    return "spawn";
			3'd1:    return "chase";
			3'd2:    return "hit_score";
			3'd3:    return "shot_order";
			default: return "player_hit";
		endcase
	endfunction

	// one cell in direction d, off set when that cell is outside the field
	function automatic tank_pkg::pos_t next_bul_pos(tank_pkg::pos_t b, tank_pkg::dir_e d,
	                                                output logic off_field);
		int nx;
		int ny;
		nx = int'(b.x);
		ny = int'(b.y);
		case (d)
			tank_pkg::dir_up:   ny = ny - 1;
			tank_pkg::dir_down: ny = ny + 1;
			tank_pkg::dir_left: nx = nx - 1;
			default:            nx = nx + 1;
		endcase
		off_field = (nx < 0) || (ny < 0) || (nx > `TANK_X_MAX) || (ny > `TANK_Y_MAX);
		if (off_field)
			return b;
		return '{x: tank_pkg::coord_t'(nx), y: tank_pkg::coord_t'(ny)};
	endfunction

	// chase rule, returns new cell and heading of one step
	function automatic tank_pkg::shot_t next_enemy_pos(tank_pkg::pos_t e, tank_pkg::pos_t p,
	                                                   output logic fires);
		tank_pkg::dir_e d;
		int             hd;
		int             vd;
		logic           edge_hit;
		tank_pkg::pos_t q;
		fires = 1'b0;
		d     = tank_pkg::dir_up;
		hd    = (e.x > p.x) ? int'(e.x) - int'(p.x) : int'(p.x) - int'(e.x);
		vd    = (e.y > p.y) ? int'(e.y) - int'(p.y) : int'(p.y) - int'(e.y);
		if (e == p)
			return '{pos: e, dir: d};                     // holds on the player
		if (hd == 0 || vd == 0)
			fires = 1'b1;                                 // lined up
		if (hd == 0 || (vd != 0 && hd >= vd))
			d = (e.y < p.y) ? tank_pkg::dir_down : tank_pkg::dir_up;
		else
			d = (e.x < p.x) ? tank_pkg::dir_right : tank_pkg::dir_left;
		q = next_bul_pos(e, d, edge_hit);
		return '{pos: q, dir: d};
	endfunction

	function automatic tank_pkg::pos_t corner(logic [1:0] n);
		case (n)
			2'd0:    return '{x: 5'd0, y: 5'd0};
			2'd1:    return '{x: 5'd`TANK_SPAWN_X1, y: 5'd0};
			2'd2:    return '{x: 5'd0, y: 5'd`TANK_SPAWN_Y1};
			default: return '{x: 5'd`TANK_SPAWN_X1, y: 5'd`TANK_SPAWN_Y1};
		endcase
	endfunction

	task automatic report_value(string what, int exp_v, int act_v);
		$display("error %s: %s expected %h actual %h", test_name(test_num), what, exp_v, act_v);
		errs++;
	endtask

	task automatic report_plain(string msg);
		$display("%s: %s", test_name(test_num), msg);
		errs++;
	endtask

	// ------------------------------------------------------------------------
	// comparison on the falling edge, all DUT outputs settled
	// ------------------------------------------------------------------------
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			size_before = shot_q.size();
			if (bul_active && !prev_active)
			begin
				if (size_before == 0)
					report_plain("bullet launched with no shot queued");
				else
				begin
					front = shot_q.pop_front();          // oldest shot first
					fly_dir = front.dir;
					if (bul_pos != front.pos)
						report_value("launch position", int'(front.pos), int'(bul_pos));
				end
			end
			if (pend && size_before < `TANK_FIFO_DEPTH)
				shot_q.push_back(pend_shot);             // full queue drops it
			pend = 1'b0;
			if (prev_active && bul_active && bul_pos != prev_bul)
			begin
				exp_pos = next_bul_pos(prev_bul, fly_dir, off);
				if (off || bul_pos != exp_pos)
					report_value("bullet step", int'(exp_pos), int'(bul_pos));
			end
			if (prev_active && !bul_active && !player_hit)
			begin
				exp_pos = next_bul_pos(prev_bul, fly_dir, off);
				if (!off)
					report_plain("bullet retired inside the field");
			end
			if (player_hit && (!prev_active || bul_active || prev_bul != prev_player))
				report_plain("player_hit without a bullet on the player");
			if (prev_active && prev_enable && prev_bul == prev_player && !player_hit)
				report_plain("bullet reached the player but player_hit stayed low");
			if (enemy_alive && !prev_alive && enemy_pos != corner(prev_tnum))
				report_value("spawn corner", int'(corner(prev_tnum)), int'(enemy_pos));
			if (!enemy_alive && prev_alive)
			begin
				if (!(prev_pos == prev_player || (prev_bulv && prev_pos == prev_bulp)))
					report_plain("tank died without touching the player or its bullet");
				if (score != 5'(prev_score + 5'd1))
					report_value("score after kill", int'(5'(prev_score + 5'd1)), int'(score));
			end
			if (enemy_alive && prev_alive && enemy_pos != prev_pos)
			begin
				if (prev_frozen || !prev_enable)
					report_plain("tank moved while frozen or disabled");
				nxt = next_enemy_pos(prev_pos, prev_player, fire);
				if (enemy_pos != nxt.pos)
					report_value("chase position", int'(nxt.pos), int'(enemy_pos));
				if (enemy_dir != nxt.dir)
					report_value("chase direction", int'(nxt.dir), int'(enemy_dir));
				pend      = fire;
				pend_shot = nxt;
			end
			if (enemy_pos.x > 5'd`TANK_X_MAX || enemy_pos.y > 5'd`TANK_Y_MAX)
				report_plain("tank left the field");
			if (!prev_enable && score != 5'd0)
				report_value("score while disabled", 0, int'(score));
			if (tb_fail)
				errs++;
			if (test_end)
			begin
				if (errs == 0)
					$display("test %s: passed", test_name(test_num));
				else
				begin
					$display("test %s: failed with %0d errors", test_name(test_num), errs);
					n_fail = n_fail + 1;
				end
				n_err = n_err + errs;
				errs  = 0;
			end
		end
		else
		begin
			shot_q.delete();                             // queue empties in reset
			pend   = 1'b0;
			errs   = 0;
			n_fail = 0;
			n_err  = 0;
		end
		prev_pos    = enemy_pos;
		prev_bul    = bul_pos;
		prev_player = player_pos;
		prev_bulp   = player_bul_pos;
		prev_bulv   = player_bul_valid;
		prev_alive  = enemy_alive;
		prev_active = bul_active;
		prev_frozen = frozen;
		prev_enable = enable;
		prev_score  = score;
		prev_tnum   = tank_num;
	end

endmodule

// ==== rtl/enemy_top.sv ====
`timescale 1ns/1ps

module enemy_top (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            enable,
	input  logic            respawn,
	input  logic            frozen,
	input  logic [1:0]      tank_num,
	input  tank_pkg::pos_t  player_pos,
	input  tank_pkg::pos_t  player_bul_pos,
	input  logic            player_bul_valid,
	output tank_pkg::pos_t  enemy_pos,
	output tank_pkg::dir_e  enemy_dir,
	output logic            enemy_alive,
	output logic [4:0]      score,
	output tank_pkg::pos_t  bul_pos,
	output logic            bul_active,
	output logic            player_hit
);

	logic            step;                        // movement strobe
	logic            shot_push;
	logic            shot_pop;
	logic            shot_empty;
	tank_pkg::shot_t shot;                        // tank to queue
	tank_pkg::shot_t head;                        // queue to bullet

	// ------------------------------------------------------------------------
	// step source, shot producer, queue and consumer
	// ------------------------------------------------------------------------
	step_tick i_step_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.enable (enable),
		.step   (step)
	);

	enemy_tank i_enemy_tank (
		.clk              (clk),
		.rst_n            (rst_n),
		.enable           (enable),
		.step             (step),
		.respawn          (respawn),
		.frozen           (frozen),
		.tank_num         (tank_num),
		.player_pos       (player_pos),
		.player_bul_pos   (player_bul_pos),
		.player_bul_valid (player_bul_valid),
		.enemy_pos        (enemy_pos),
		.enemy_dir        (enemy_dir),
		.enemy_alive      (enemy_alive),
		.score            (score),
		.shot_push        (shot_push),
		.shot             (shot)
	);

	shot_fifo i_shot_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (shot_push),
		.pop        (shot_pop),
		.din        (shot),
		.head       (head),
		.shot_empty (shot_empty)
	);

	enemy_bullet i_enemy_bullet (
		.clk        (clk),
		.rst_n      (rst_n),
		.enable     (enable),
		.step       (step),
		.player_pos (player_pos),
		.head       (head),
		.shot_empty (shot_empty),
		.shot_pop   (shot_pop),
		.bul_pos    (bul_pos),
		.bul_active (bul_active),
		.player_hit (player_hit)
	);

endmodule

// ==== rtl/enemy_bullet.sv ====
`timescale 1ns/1ps

module enemy_bullet (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            enable,
	input  logic            step,
	input  tank_pkg::pos_t  player_pos,
	input  tank_pkg::shot_t head,
	input  logic            shot_empty,
	output logic            shot_pop,
	output tank_pkg::pos_t  bul_pos,
	output logic            bul_active,
	output logic            player_hit
);

	typedef enum logic {
		b_idle = 1'b0,
		b_fly  = 1'b1
	} bul_st_e;

	bul_st_e        state;
	tank_pkg::dir_e bul_dir;                      // heading of the live bullet
	logic           on_player;

	assign shot_pop   = enable && (state == b_idle) && !shot_empty;   // fetch next shot
	assign bul_active = (state == b_fly);
	assign on_player  = (bul_pos == player_pos);

	// ------------------------------------------------------------------------
	// launch, flight and retire
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= b_idle;
			bul_pos    <= '0;
			bul_dir    <= tank_pkg::dir_up;
			player_hit <= 1'b0;
		end
		else
		begin
			player_hit <= 1'b0;
			if (enable)
			begin
				case (state)
					b_idle:
						if (shot_pop)
						begin
							bul_pos <= head.pos;          // start at the firing cell
							bul_dir <= head.dir;
							state   <= b_fly;
						end
					b_fly:
						if (on_player)
						begin
							player_hit <= 1'b1;           // one clock pulse
							state      <= b_idle;
						end
						else if (step)
						begin
							if (tank_pkg::can_move(bul_pos, bul_dir))
								bul_pos <= tank_pkg::move_pos(bul_pos, bul_dir);
							else
								state <= b_idle;          // next cell off the field
						end
					default:
						state <= b_idle;
				endcase
			end
		end
	end

endmodule

// ==== rtl/shot_fifo.sv ====
`timescale 1ns/1ps
`include "tank_cfg.svh"

module shot_fifo (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            push,
	input  logic            pop,
	input  tank_pkg::shot_t din,
	output tank_pkg::shot_t head,
	output logic            shot_empty
);

	localparam int DEPTH = `TANK_FIFO_DEPTH;
	localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	tank_pkg::shot_t mem [DEPTH];
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic [AW:0]     count;                       // entries held
	logic            full;
	logic            do_push;
	logic            do_pop;

	assign full       = (count == (AW+1)'(DEPTH));
	assign shot_empty = (count == '0);
	assign do_push    = push && !full;            // push into full queue lost
	assign do_pop     = pop && !shot_empty;
	assign head       = mem[rd_ptr];              // show-ahead

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
			if (do_push && !do_pop)
				count <= count + (AW+1)'(1);
			else if (do_pop && !do_push)
				count <= count - (AW+1)'(1);
		end
	end

endmodule

// ==== rtl/enemy_tank.sv ====
`timescale 1ns/1ps
`include "tank_cfg.svh"

module enemy_tank (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              enable,
	input  logic              step,
	input  logic              respawn,
	input  logic              frozen,
	input  logic [1:0]        tank_num,
	input  tank_pkg::pos_t    player_pos,
	input  tank_pkg::pos_t    player_bul_pos,
	input  logic              player_bul_valid,
	output tank_pkg::pos_t    enemy_pos,
	output tank_pkg::dir_e    enemy_dir,
	output logic              enemy_alive,
	output logic [4:0]        score,
	output logic              shot_push,
	output tank_pkg::shot_t   shot
);

	tank_pkg::tank_st_e state;
	logic               eql;                      // sitting on the player
	logic [4:0]         h_dis;                    // |ex - px|
	logic [4:0]         v_dis;                    // |ey - py|
	logic               x_lt;                     // player to the right
	logic               y_lt;                     // player below
	logic               hit;
	logic               mv_en;
	logic               fire;
	tank_pkg::dir_e     mv_dir;
	tank_pkg::pos_t     new_pos;
	tank_pkg::pos_t     corner;

	// ------------------------------------------------------------------------
	// distance and side to the player, one clock behind the position
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			eql   <= 1'b0;
			h_dis <= '0;
			v_dis <= '0;
			x_lt  <= 1'b0;
			y_lt  <= 1'b0;
		end
		else if (enable)
		begin
			eql  <= (enemy_pos == player_pos);
			x_lt <= (enemy_pos.x < player_pos.x);
			y_lt <= (enemy_pos.y < player_pos.y);
			if (enemy_pos.x < player_pos.x)
				h_dis <= player_pos.x - enemy_pos.x;
			else
				h_dis <= enemy_pos.x - player_pos.x;
			if (enemy_pos.y < player_pos.y)
				v_dis <= player_pos.y - enemy_pos.y;
			else
				v_dis <= enemy_pos.y - player_pos.y;
		end
	end

	// ------------------------------------------------------------------------
	// chase rule
	// ------------------------------------------------------------------------
	always_comb
	begin
		mv_en  = 1'b1;
		fire   = 1'b0;
		mv_dir = enemy_dir;
		if (eql)
			mv_en = 1'b0;                         // already on the player, hold
		else if (h_dis == 5'd0)
		begin
			mv_dir = y_lt ? tank_pkg::dir_down : tank_pkg::dir_up;
			fire   = 1'b1;                        // same column
		end
		else if (v_dis == 5'd0)
		begin
			mv_dir = x_lt ? tank_pkg::dir_right : tank_pkg::dir_left;
			fire   = 1'b1;                        // same row
		end
		else if (h_dis < v_dis)
			mv_dir = x_lt ? tank_pkg::dir_right : tank_pkg::dir_left;
		else
			mv_dir = y_lt ? tank_pkg::dir_down : tank_pkg::dir_up;
	end

	assign new_pos = mv_en ? tank_pkg::move_pos(enemy_pos, mv_dir) : enemy_pos;

	// spawn corner from tank_num, bit 0 picks the column
	assign corner.x = tank_num[0] ? tank_pkg::coord_t'(`TANK_SPAWN_X1) : tank_pkg::coord_t'(0);
	assign corner.y = tank_num[1] ? tank_pkg::coord_t'(`TANK_SPAWN_Y1) : tank_pkg::coord_t'(0);

	assign hit = (enemy_pos == player_pos) ||
	             (player_bul_valid && (enemy_pos == player_bul_pos));

	assign enemy_alive = (state == tank_pkg::st_alive);

	// ------------------------------------------------------------------------
	// tank FSM, position and score
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= tank_pkg::st_dead;
			enemy_pos <= '0;
			enemy_dir <= tank_pkg::dir_up;
			score     <= '0;
			shot_push <= 1'b0;
		end
		else if (!enable)
		begin
			score     <= '0;                      // game off, state holds
			shot_push <= 1'b0;
		end
		else
		begin
			shot_push <= 1'b0;
			case (state)
				tank_pkg::st_dead:
					if (respawn)
						state <= tank_pkg::st_spawn;
				tank_pkg::st_spawn:
					if (step)
					begin
						enemy_pos <= corner;
						state     <= tank_pkg::st_alive;
					end
				tank_pkg::st_alive:
					if (hit)
					begin
						state <= tank_pkg::st_dead;   // hit wins over movement
						score <= score + 5'd1;
					end
					else if (step && !frozen)
					begin
						enemy_pos <= new_pos;
						if (new_pos != enemy_pos)
							enemy_dir <= mv_dir;      // only a taken move turns
						shot_push <= fire;
					end
				default:
					state <= tank_pkg::st_dead;
			endcase
		end
	end

	// shot payload, meaningful only with shot_push
	always_ff @(posedge clk)
	begin
		if (step)
		begin
			shot.pos <= new_pos;
			shot.dir <= mv_dir;
		end
	end

endmodule

// ==== rtl/step_tick.sv ====
`timescale 1ns/1ps
`include "tank_cfg.svh"

module step_tick (
	input  logic clk,
	input  logic rst_n,
	input  logic enable,
	output logic step
);

	localparam int DIV = `TANK_STEP_DIV;
	localparam int CW  = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt;                           // clocks since last strobe

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt  <= '0;
			step <= 1'b0;
		end
		else if (enable)
		begin
			step <= (cnt == CW'(DIV - 1));        // strobe on the wrap
			if (cnt == CW'(DIV - 1))
				cnt <= '0;
			else
				cnt <= cnt + CW'(1);
		end
		else
			step <= 1'b0;                         // counter frozen, no strobe
	end

endmodule

// ==== rtl/tank_pkg.sv ====
`include "tank_cfg.svh"

package tank_pkg;

	typedef logic [4:0] coord_t;                  // one grid coordinate

	typedef struct packed {
		coord_t x;                                // column
		coord_t y;                                // row, 0 at the top
	} pos_t;

	typedef enum logic [1:0] {
		dir_up    = 2'd0,                         // y - 1
		dir_down  = 2'd1,                         // y + 1
		dir_left  = 2'd2,                         // x - 1
		dir_right = 2'd3                          // x + 1
	} dir_e;

	typedef enum logic [1:0] {
		st_dead  = 2'd0,
		st_spawn = 2'd1,                          // waiting for a step to appear
		st_alive = 2'd2
	} tank_st_e;

	typedef struct packed {
		pos_t pos;                                // cell where the shot starts
		dir_e dir;                                // flight direction
	} shot_t;

	// true when one cell in direction d stays on the field
	function automatic logic can_move(pos_t p, dir_e d);
		case (d)
			dir_up:   return p.y != coord_t'(0);
			dir_down: return p.y != coord_t'(`TANK_Y_MAX);
			dir_left: return p.x != coord_t'(0);
			default:  return p.x != coord_t'(`TANK_X_MAX);
		endcase
	endfunction

	// one cell step, position unchanged at the edge
	function automatic pos_t move_pos(pos_t p, dir_e d);
		pos_t q;
		q = p;
		if (can_move(p, d))
		begin
			case (d)
				dir_up:   q.y = p.y - coord_t'(1);
				dir_down: q.y = p.y + coord_t'(1);
				dir_left: q.x = p.x - coord_t'(1);
				default:  q.x = p.x + coord_t'(1);
			endcase
		end
		return q;
	endfunction

endpackage

// ==== rtl/tank_cfg.svh ====
`ifndef TANK_CFG_SVH
`define TANK_CFG_SVH

// ---------------------------------------------------------------------------
// field limits, 17 columns by 21 rows
// ---------------------------------------------------------------------------
`define TANK_X_MAX 16              // last column
`define TANK_Y_MAX 20              // last row

// ---------------------------------------------------------------------------
// timing and buffering
// ---------------------------------------------------------------------------
`define TANK_STEP_DIV 4            // clocks per movement step, short for sim
`define TANK_FIFO_DEPTH 4          // queued shots

// far spawn corner, the near one is the origin
`define TANK_SPAWN_X1 16
`define TANK_SPAWN_Y1 12

`endif
